// ==== build.f ====
svm_geom_pkg.sv
svm_num_pkg.sv
coef_ram.sv
svm_cfg_regs.sv
svm_pe.sv
row_delay.sv
svm_ctrl.sv
svm_array.sv
svm_top.sv
svm_assert.sv
svm_tb.sv

// ==== Bender.yml ====
package:
  name: svm_hog

sources:
  - svm_geom_pkg.sv
  - svm_num_pkg.sv
  - coef_ram.sv
  - svm_cfg_regs.sv
  - svm_pe.sv
  - row_delay.sv
  - svm_ctrl.sv
  - svm_array.sv
  - svm_top.sv
  - target: simulation
    files:
      - svm_assert.sv
      - svm_tb.sv

// ==== svm_tb.sv ====
// testbench with clock, reset, host programming, random frames, reference model and checks
`timescale 1ns/10ps

module svm_tb;

    localparam int WATCHDOG_CYCLES = 4 * svm_geom_pkg::FEATS_PER_FRAME * 3 + 200;

    logic                              clk;
    logic                              rst;
    logic [svm_geom_pkg::ADDR_W-1:0]   i_coef_addr;
    logic                              i_coef_we;
    logic [svm_num_pkg::RAM_DW-1:0]    i_coef_wdata;
    logic [svm_num_pkg::RAM_DW-1:0]    o_coef_rdata;
    logic                              i_reg_addr;
    logic                              i_reg_we;
    logic [svm_num_pkg::ACC_W-1:0]     i_reg_wdata;
    logic [svm_num_pkg::ACC_W-1:0]     o_reg_rdata;
    logic                              i_valid;
    logic [svm_num_pkg::FEA_W-1:0]     i_fea;
    logic                              o_valid;
    logic [svm_num_pkg::ACC_W-1:0]     o_score;
    logic                              o_is_person;
    logic [svm_geom_pkg::WIN_ID_W-1:0] o_window_id;

    // reference copies with two frame buffers for back-to-back frames
    logic [svm_num_pkg::RAM_DW-1:0] coef_mem   [svm_geom_pkg::FEATS];
    logic [svm_num_pkg::FEA_W-1:0]  frame_fea  [2][svm_geom_pkg::FEATS_PER_FRAME];
    logic [svm_num_pkg::FEA_W-1:0]  frame_bias [2];
    logic [svm_num_pkg::ACC_W-1:0]  cur_thresh;
    logic [svm_num_pkg::ACC_W-1:0]  exp_score;
    int                             res_cnt;

    svm_top svm_top_inst (.*);

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act) else begin
            $display("error: %s expected 0x%h actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    // window score from bias, coefficients and the recorded frame
    function automatic logic [svm_num_pkg::ACC_W-1:0] expected_score(input int par,
                                                                     input int w);
        logic signed [63:0]                     acc;
        logic signed [svm_num_pkg::COEF_W-1:0]  cf;
        logic signed [svm_num_pkg::FEA_W-1:0]   fv;
        int                                     top;
        int                                     left;
        int                                     blk;
        top  = w / svm_geom_pkg::WIN_X;
        left = w % svm_geom_pkg::WIN_X;
        acc  = $signed(frame_bias[par]);
        acc  = acc <<< svm_num_pkg::BIAS_SHIFT;
        for (int r = 0; r < svm_geom_pkg::ROW; r++) begin
            for (int c = 0; c < svm_geom_pkg::COL; c++) begin
                blk = (top + r) * svm_geom_pkg::GRID_W + left + c;
                for (int f = 0; f < svm_geom_pkg::FEATS; f++) begin
                    cf  = coef_mem[f][(r * svm_geom_pkg::COL + c) * svm_num_pkg::COEF_W
                                      +: svm_num_pkg::COEF_W];
                    fv  = frame_fea[par][blk * svm_geom_pkg::FEATS + f];
                    acc = acc + cf * fv;
                end
            end
        end
        return acc[svm_num_pkg::ACC_W-1:0];
    endfunction

    task automatic write_coef(input int addr, input logic [svm_num_pkg::RAM_DW-1:0] data);
        i_coef_addr  = addr;
        i_coef_wdata = data;
        i_coef_we    = 1'b1;
        @(posedge clk); #2;
        i_coef_we    = 1'b0;
        coef_mem[addr] = data;
    endtask

    // registered read shows the word after the next edge
    task automatic read_coef(input int addr);
        i_coef_addr = addr;
        @(posedge clk); #1;
        check_value("o_coef_rdata", coef_mem[addr], o_coef_rdata);
        #1;
    endtask

    task automatic write_reg(input logic addr, input logic [svm_num_pkg::ACC_W-1:0] data);
        i_reg_addr  = addr;
        i_reg_wdata = data;
        i_reg_we    = 1'b1;
        @(posedge clk); #2;
        i_reg_we    = 1'b0;
    endtask

    task automatic read_reg(input logic addr, input logic [svm_num_pkg::ACC_W-1:0] exp);
        i_reg_addr = addr;
        #1;
        check_value("o_reg_rdata", exp, o_reg_rdata);
        @(posedge clk); #2;
    endtask

    // random signed bias in feature format
    task automatic program_bias(input int par);
        logic [svm_num_pkg::FEA_W-1:0] b;
        b = $urandom;
        frame_bias[par] = b;
        write_reg(svm_num_pkg::REG_BIAS, svm_num_pkg::ACC_W'(b));
        read_reg(svm_num_pkg::REG_BIAS, svm_num_pkg::ACC_W'($signed(b)));
    endtask

    task automatic program_thresh(input logic [svm_num_pkg::ACC_W-1:0] t);
        cur_thresh = t;
        write_reg(svm_num_pkg::REG_THRESH, t);
        read_reg(svm_num_pkg::REG_THRESH, t);
    endtask

    task automatic send_frame(input int par, input bit with_gaps);
        logic [svm_num_pkg::FEA_W-1:0] fea;
        int                            idle;
        for (int i = 0; i < svm_geom_pkg::FEATS_PER_FRAME; i++) begin
            idle = 0;
            if (with_gaps && ($urandom % 2 == 1)) begin
                idle = $urandom_range(1, 2);
            end
            repeat (idle) begin
                i_valid = 1'b0;
                i_fea   = $urandom;
                @(posedge clk); #2;
            end
            fea = $urandom;
            frame_fea[par][i] = fea;
            i_valid = 1'b1;
            i_fea   = fea;
            @(posedge clk); #2;
        end
        i_valid = 1'b0;
    endtask

    // result checker sampled away from the active edge
    always @(negedge clk) begin
        if (o_valid === 1'b1) begin
            exp_score = expected_score((res_cnt / svm_geom_pkg::N_WIN) % 2,
                                       res_cnt % svm_geom_pkg::N_WIN);
            check_value("o_window_id", res_cnt % svm_geom_pkg::N_WIN, o_window_id);
            check_value("o_score", exp_score, o_score);
            check_value("o_is_person", $signed(exp_score) >= $signed(cur_thresh), o_is_person);
            res_cnt++;
        end
        if (svm_top_inst.u_assert.err_cnt != 0) begin
            $display("a bound assertion on the DUT outputs failed");
            abort_run();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish in time");
        abort_run();
    end

    initial begin
        void'($urandom(32'h5b413bb5));
        clk          = 1'b0;
        rst          = 1'b0;
        i_coef_addr  = '0;
        i_coef_we    = 1'b0;
        i_coef_wdata = '0;
        i_reg_addr   = 1'b0;
        i_reg_we     = 1'b0;
        i_reg_wdata  = '0;
        i_valid      = 1'b0;
        i_fea        = '0;
        cur_thresh   = '0;
        res_cnt      = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;

        for (int a = 0; a < svm_geom_pkg::FEATS; a++) begin
            write_coef(a, {$urandom, $urandom});
        end
        for (int a = 0; a < svm_geom_pkg::FEATS; a++) begin
            read_coef(a);
        end

        // first frame with gaps and zero threshold
        program_bias(0);
        program_thresh('0);
        send_frame(0, 1'b1);
        repeat (3) @(posedge clk);
        #2;
        check_value("result count", svm_geom_pkg::N_WIN, res_cnt);

        // second frame with new bias and threshold
        program_bias(1);
        program_thresh(svm_num_pkg::ACC_W'($signed(24'($urandom))));
        send_frame(1, 1'b1);
        repeat (3) @(posedge clk);
        #2;
        check_value("result count", 2 * svm_geom_pkg::N_WIN, res_cnt);

        // third and fourth frames back to back
        frame_bias[0] = frame_bias[1];
        send_frame(0, 1'b0);
        send_frame(1, 1'b0);
        repeat (3) @(posedge clk);
        #2;

        if (res_cnt != 4 * svm_geom_pkg::N_WIN) begin
            $display("error: result count expected 0x%h actual 0x%h",
                     4 * svm_geom_pkg::N_WIN, res_cnt);
            abort_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== svm_assert.sv ====
// bound checks on result valid timing, person flag and window index order
`timescale 1ns/10ps

module svm_assert (
    input logic                              clk,
    input logic                              rst,
    input logic                              i_valid,
    input logic                              i_reg_addr,
    input logic                              i_reg_we,
    input logic [svm_num_pkg::ACC_W-1:0]     i_reg_wdata,
    input logic                              o_valid,
    input logic [svm_num_pkg::ACC_W-1:0]     o_score,
    input logic                              o_is_person,
    input logic [svm_geom_pkg::WIN_ID_W-1:0] o_window_id
);

    int                                err_cnt = 0;
    logic [svm_geom_pkg::WIN_ID_W-1:0] last_id;
    logic [svm_num_pkg::ACC_W-1:0]     thresh_host;
    int                                feat_cnt;
    logic                              win_close;

    always_ff @(posedge clk) begin
        if (!rst) begin
            last_id <= '0;
        end else if (o_valid) begin
            last_id <= o_window_id;
        end
    end

    // threshold as written on the host port
    always_ff @(posedge clk) begin
        if (!rst) begin
            thresh_host <= '0;
        end else if (i_reg_we && (i_reg_addr == svm_num_pkg::REG_THRESH)) begin
            thresh_host <= i_reg_wdata;
        end
    end

    // accepted features within the frame
    always_ff @(posedge clk) begin
        if (!rst) begin
            feat_cnt <= 0;
        end else if (i_valid) begin
            feat_cnt <= (feat_cnt + 1) % svm_geom_pkg::FEATS_PER_FRAME;
        end
    end

    // last feature of a block that is the bottom-right of a window
    assign win_close = i_valid &&
        ((feat_cnt % svm_geom_pkg::FEATS) == svm_geom_pkg::FEATS - 1) &&
        (((feat_cnt / svm_geom_pkg::FEATS) % svm_geom_pkg::GRID_W) >= svm_geom_pkg::COL - 1) &&
        ((feat_cnt / (svm_geom_pkg::FEATS * svm_geom_pkg::GRID_W)) >= svm_geom_pkg::ROW - 1);

    // no result while reset is held
    a_reset_quiet: assert property (@(posedge clk) (!rst ##1 !rst) |-> !o_valid)
        else begin
            $error("o_valid high during reset");
            err_cnt++;
        end

    // result exactly one cycle after a window closes
    a_valid_timing: assert property (@(posedge clk) disable iff (!rst)
        o_valid == $past(win_close))
        else begin
            $error("o_valid does not follow the closing feature of a window");
            err_cnt++;
        end

    a_flag: assert property (@(posedge clk) disable iff (!rst)
        o_valid |-> (o_is_person == ($signed(o_score) >= $signed(thresh_host))))
        else begin
            $error("o_is_person does not match the threshold compare");
            err_cnt++;
        end

    // window index steps by one inside a frame
    a_id_order: assert property (@(posedge clk) disable iff (!rst)
        (o_valid && (o_window_id != '0)) |-> (o_window_id == last_id + 1'b1))
        else begin
            $error("o_window_id out of order");
            err_cnt++;
        end

    a_id_range: assert property (@(posedge clk) disable iff (!rst)
        o_valid |-> (o_window_id < svm_geom_pkg::WIN_ID_W'(svm_geom_pkg::N_WIN)))
        else begin
            $error("o_window_id beyond the last window");
            err_cnt++;
        end

endmodule

bind svm_top svm_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (i_valid),
    .i_reg_addr  (i_reg_addr),
    .i_reg_we    (i_reg_we),
    .i_reg_wdata (i_reg_wdata),
    .o_valid     (o_valid),
    .o_score     (o_score),
    .o_is_person (o_is_person),
    .o_window_id (o_window_id)
);

// ==== svm_top.sv ====
// top level with coefficient RAM, config registers, controller, PE array and threshold compare
`timescale 1ns/10ps

module svm_top (
    input  logic                              clk,
    input  logic                              rst,
    // host coefficient port
    input  logic [svm_geom_pkg::ADDR_W-1:0]   i_coef_addr,
    input  logic                              i_coef_we,
    input  logic [svm_num_pkg::RAM_DW-1:0]    i_coef_wdata,
    output logic [svm_num_pkg::RAM_DW-1:0]    o_coef_rdata,
    // host register port
    input  logic                              i_reg_addr,
    input  logic                              i_reg_we,
    input  logic [svm_num_pkg::ACC_W-1:0]     i_reg_wdata,
    output logic [svm_num_pkg::ACC_W-1:0]     o_reg_rdata,
    // feature stream
    input  logic                              i_valid,
    input  logic [svm_num_pkg::FEA_W-1:0]     i_fea,
    // window results
    output logic                              o_valid,
    output logic [svm_num_pkg::ACC_W-1:0]     o_score,
    output logic                              o_is_person,
    output logic [svm_geom_pkg::WIN_ID_W-1:0] o_window_id
);

    logic [svm_geom_pkg::ADDR_W-1:0]  rd_addr;
    logic [svm_num_pkg::RAM_DW-1:0]   coef_word;
    logic [svm_num_pkg::ACC_W-1:0]    bias_q;
    logic [svm_num_pkg::ACC_W-1:0]    thresh_q;
    logic                             pe_en;
    logic                             pe_init;
    logic                             blk_step;

    coef_ram u_coef_ram (
        .clk       (clk),
        .i_addr_a  (i_coef_addr),
        .i_we_a    (i_coef_we),
        .i_wdata_a (i_coef_wdata),
        .o_rdata_a (o_coef_rdata),
        .i_addr_b  (rd_addr),
        .o_rdata_b (coef_word)
    );

    svm_cfg_regs u_cfg_regs (
        .clk      (clk),
        .rst      (rst),
        .i_addr   (i_reg_addr),
        .i_we     (i_reg_we),
        .i_wdata  (i_reg_wdata),
        .o_rdata  (o_reg_rdata),
        .o_bias   (bias_q),
        .o_thresh (thresh_q)
    );

    svm_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .o_rd_addr   (rd_addr),
        .o_pe_en     (pe_en),
        .o_pe_init   (pe_init),
        .o_blk_step  (blk_step),
        .o_valid     (o_valid),
        .o_window_id (o_window_id)
    );

    svm_array u_array (
        .clk         (clk),
        .rst         (rst),
        .i_en        (pe_en),
        .i_init      (pe_init),
        .i_step      (blk_step),
        .i_fea       (i_fea),
        .i_coef_word (coef_word),
        .i_bias      (bias_q),
        .o_score     (o_score)
    );

    // signed score against the programmed threshold
    assign o_is_person = $signed(o_score) >= $signed(thresh_q);

endmodule

// ==== svm_array.sv ====
// PE grid with row delays and coefficient word unpacking
`timescale 1ns/10ps

module svm_array (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_en,
    input  logic                            i_init,
    input  logic                            i_step,
    input  logic [svm_num_pkg::FEA_W-1:0]   i_fea,
    input  logic [svm_num_pkg::RAM_DW-1:0]  i_coef_word,
    input  logic [svm_num_pkg::ACC_W-1:0]   i_bias,
    output logic [svm_num_pkg::ACC_W-1:0]   o_score
);

    logic [svm_num_pkg::COEF_W-1:0] coef    [svm_geom_pkg::N_PE];
    logic [svm_num_pkg::ACC_W-1:0]  pe_in   [svm_geom_pkg::ROW][svm_geom_pkg::COL];
    logic [svm_num_pkg::ACC_W-1:0]  pe_sum  [svm_geom_pkg::ROW][svm_geom_pkg::COL];
    logic [svm_num_pkg::ACC_W-1:0]  dly_out [svm_geom_pkg::ROW-1];

    // PE k takes slice k of the word
    for (genvar k = 0; k < svm_geom_pkg::N_PE; k++) begin : g_coef
        assign coef[k] = i_coef_word[k*svm_num_pkg::COEF_W +: svm_num_pkg::COEF_W];
    end

    for (genvar r = 0; r < svm_geom_pkg::ROW; r++) begin : g_row
        for (genvar c = 0; c < svm_geom_pkg::COL; c++) begin : g_col
            // neighbor select along the raster chain
            if (c > 0) begin : g_left
                assign pe_in[r][c] = pe_sum[r][c-1];
            end else if (r > 0) begin : g_up
                assign pe_in[r][c] = dly_out[r-1];
            end else begin : g_bias
                assign pe_in[r][c] = i_bias;
            end

            svm_pe u_pe (
                .clk    (clk),
                .i_en   (i_en),
                .i_init (i_init),
                .i_fea  (i_fea),
                .i_coef (coef[r*svm_geom_pkg::COL + c]),
                .i_sum  (pe_in[r][c]),
                .o_sum  (pe_sum[r][c])
            );
        end

        // row end of the row above feeds this row start
        if (r > 0) begin : g_dly
            row_delay #(
                .DATA_W (svm_num_pkg::ACC_W),
                .DEPTH  (svm_geom_pkg::ROW_DELAY)
            ) u_row_delay (
                .clk    (clk),
                .rst    (rst),
                .i_step (i_step),
                .i_data (pe_sum[r-1][svm_geom_pkg::COL-1]),
                .o_data (dly_out[r-1])
            );
        end
    end

    assign o_score = pe_sum[svm_geom_pkg::ROW-1][svm_geom_pkg::COL-1];

endmodule

// ==== svm_ctrl.sv ====
// feature, block column and block row counters with array strobes and window output
`timescale 1ns/10ps

module svm_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_valid,
    output logic [svm_geom_pkg::ADDR_W-1:0]   o_rd_addr,
    output logic                              o_pe_en,
    output logic                              o_pe_init,
    output logic                              o_blk_step,
    output logic                              o_valid,
    output logic [svm_geom_pkg::WIN_ID_W-1:0] o_window_id
);

    logic [svm_geom_pkg::ADDR_W-1:0]   feat_q;
    logic [svm_geom_pkg::COLX_W-1:0]   blk_col_q;
    logic [svm_geom_pkg::ROWX_W-1:0]   blk_row_q;
    logic                              last_feat;
    logic                              win_done;
    logic [svm_geom_pkg::ROWX_W-1:0]   win_row;
    logic [svm_geom_pkg::COLX_W-1:0]   win_col;
    logic [svm_geom_pkg::WIN_ID_W-1:0] win_id;
    logic                              valid_q;
    logic [svm_geom_pkg::WIN_ID_W-1:0] win_id_q;

    assign last_feat = (feat_q == svm_geom_pkg::FEAT_LAST);

    // raster counters, frames wrap back to block 0,0
    always_ff @(posedge clk) begin
        if (!rst) begin
            feat_q    <= '0;
            blk_col_q <= '0;
            blk_row_q <= '0;
        end else if (i_valid) begin
            if (last_feat) begin
                feat_q <= '0;
                if (blk_col_q == svm_geom_pkg::COL_LAST) begin
                    blk_col_q <= '0;
                    if (blk_row_q == svm_geom_pkg::ROW_LAST) begin
                        blk_row_q <= '0;
                    end else begin
                        blk_row_q <= blk_row_q + 1'b1;
                    end
                end else begin
                    blk_col_q <= blk_col_q + 1'b1;
                end
            end else begin
                feat_q <= feat_q + 1'b1;
            end
        end
    end

    // last feature of a block that closes a window
    assign win_done = i_valid && last_feat &&
                      (blk_col_q >= svm_geom_pkg::WIN_COL0) &&
                      (blk_row_q >= svm_geom_pkg::WIN_ROW0);

    // window origin from the bottom-right block
    assign win_row = blk_row_q - svm_geom_pkg::WIN_ROW0;
    assign win_col = blk_col_q - svm_geom_pkg::WIN_COL0;
    assign win_id  = {{(svm_geom_pkg::WIN_ID_W - svm_geom_pkg::ROWX_W){1'b0}}, win_row} *
                     svm_geom_pkg::WIN_X_ID +
                     {{(svm_geom_pkg::WIN_ID_W - svm_geom_pkg::COLX_W){1'b0}}, win_col};

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= win_done;
        end
    end

    always_ff @(posedge clk) begin
        if (win_done) begin
            win_id_q <= win_id;
        end
    end

    assign o_rd_addr   = feat_q;
    assign o_pe_en     = i_valid;
    assign o_pe_init   = i_valid && (feat_q == '0);
    // delays advance once per block start
    assign o_blk_step  = o_pe_init;
    assign o_valid     = valid_q;
    assign o_window_id = win_id_q;

endmodule

// ==== row_delay.sv ====
// block-stepped shift line carrying partial sums down one array row
`timescale 1ns/10ps

module row_delay #(
    parameter int DATA_W = 28,
    parameter int DEPTH  = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_step,
    input  logic [DATA_W-1:0] i_data,
    output logic [DATA_W-1:0] o_data
);

    logic [DATA_W-1:0] line_q [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                line_q[i] <= '0;
            end
        end else if (i_step) begin
            line_q[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // oldest entry, consumed on the same step that shifts it out
    assign o_data = line_q[DEPTH-1];

endmodule

// ==== svm_pe.sv ====
// multiply-accumulate element holding the partial score of one window
`timescale 1ns/10ps

module svm_pe (
    input  logic                                 clk,
    input  logic                                 i_en,
    input  logic                                 i_init,
    input  logic signed [svm_num_pkg::FEA_W-1:0] i_fea,
    input  logic signed [svm_num_pkg::COEF_W-1:0] i_coef,
    input  logic        [svm_num_pkg::ACC_W-1:0] i_sum,
    output logic        [svm_num_pkg::ACC_W-1:0] o_sum
);

    logic signed [svm_num_pkg::PROD_W-1:0] prod;
    logic        [svm_num_pkg::ACC_W-1:0]  prod_ext;
    logic        [svm_num_pkg::ACC_W-1:0]  sum_q;

    assign prod     = i_fea * i_coef;
    assign prod_ext = {{(svm_num_pkg::ACC_W - svm_num_pkg::PROD_W){prod[svm_num_pkg::PROD_W-1]}},
                       prod};

    // block start takes the neighbor's finished sum
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_init) begin
                sum_q <= i_sum + prod_ext;
            end else begin
                sum_q <= sum_q + prod_ext;
            end
        end
    end

    assign o_sum = sum_q;

endmodule

// ==== svm_cfg_regs.sv ====
// bias and threshold registers with host write and readback
`timescale 1ns/10ps

module svm_cfg_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_addr,
    input  logic                            i_we,
    input  logic [svm_num_pkg::ACC_W-1:0]   i_wdata,
    output logic [svm_num_pkg::ACC_W-1:0]   o_rdata,
    output logic [svm_num_pkg::ACC_W-1:0]   o_bias,
    output logic [svm_num_pkg::ACC_W-1:0]   o_thresh
);

    logic [svm_num_pkg::ACC_W-1:0] bias_ext;
    logic [svm_num_pkg::ACC_W-1:0] bias_q;
    logic [svm_num_pkg::ACC_W-1:0] thresh_q;
    logic [svm_num_pkg::ACC_W-1:0] bias_rd;

    // feature-format bias sign extended then moved to score format
    assign bias_ext = {{(svm_num_pkg::ACC_W - svm_num_pkg::FEA_W){i_wdata[svm_num_pkg::FEA_W-1]}},
                       i_wdata[svm_num_pkg::FEA_W-1:0]};

    always_ff @(posedge clk) begin
        if (!rst) begin
            bias_q   <= '0;
            thresh_q <= '0;
        end else if (i_we) begin
            if (i_addr == svm_num_pkg::REG_BIAS) begin
                bias_q <= bias_ext <<< svm_num_pkg::BIAS_SHIFT;
            end else begin
                thresh_q <= i_wdata;
            end
        end
    end

    // bias reads back sign extended in feature format
    assign bias_rd = $signed(bias_q) >>> svm_num_pkg::BIAS_SHIFT;
    assign o_rdata = (i_addr == svm_num_pkg::REG_THRESH) ? thresh_q : bias_rd;

    assign o_bias   = bias_q;
    assign o_thresh = thresh_q;

endmodule

// ==== coef_ram.sv ====
// coefficient memory with registered host port and combinational array read port
`timescale 1ns/10ps

module coef_ram (
    input  logic                             clk,
    // host side
    input  logic [svm_geom_pkg::ADDR_W-1:0]  i_addr_a,
    input  logic                             i_we_a,
    input  logic [svm_num_pkg::RAM_DW-1:0]   i_wdata_a,
    output logic [svm_num_pkg::RAM_DW-1:0]   o_rdata_a,
    // array side, one word per feature index
    input  logic [svm_geom_pkg::ADDR_W-1:0]  i_addr_b,
    output logic [svm_num_pkg::RAM_DW-1:0]   o_rdata_b
);

    logic [svm_num_pkg::RAM_DW-1:0] mem [svm_geom_pkg::FEATS];

    always_ff @(posedge clk) begin
        if (i_we_a) begin
            mem[i_addr_a] <= i_wdata_a;
        end
        // old word on a same-cycle write
        o_rdata_a <= mem[i_addr_a];
    end

    // all PEs read the same word at once
    assign o_rdata_b = mem[i_addr_b];

endmodule

// ==== svm_num_pkg.sv ====
// fixed-point formats of features, coefficients, scores and register addresses
package svm_num_pkg;

    // features are signed Q4.8
    localparam int FEA_I = 4;
    localparam int FEA_F = 8;
    localparam int FEA_W = FEA_I + FEA_F;

    // coefficients share the feature format
    localparam int COEF_W = FEA_W;
    localparam int PROD_W = FEA_W + COEF_W;

    // scores carry 16 fractional bits and wrap
    localparam int ACC_W      = 28;
    localparam int BIAS_SHIFT = 8;

    // one coefficient per PE, PE k at bits k*COEF_W upward
    localparam int RAM_DW = svm_geom_pkg::N_PE * COEF_W;

    localparam logic REG_BIAS   = 1'b0;
    localparam logic REG_THRESH = 1'b1;

endpackage

// ==== svm_geom_pkg.sv ====
// feature grid, detection window and block geometry with derived counts and widths
package svm_geom_pkg;

    // feature grid of one frame
    localparam int GRID_W = 6;
    localparam int GRID_H = 4;

    // detection window in blocks
    localparam int ROW   = 2;
    localparam int COL   = 2;
    localparam int FEATS = 4;

    localparam int N_PE            = ROW * COL;
    localparam int WIN_X           = GRID_W - COL + 1;
    localparam int WIN_Y           = GRID_H - ROW + 1;
    localparam int N_WIN           = WIN_X * WIN_Y;
    localparam int ROW_DELAY       = GRID_W - COL;
    localparam int FEATS_PER_FRAME = GRID_W * GRID_H * FEATS;

    localparam int ADDR_W   = 2;
    localparam int COLX_W   = 3;
    localparam int ROWX_W   = 2;
    localparam int WIN_ID_W = 4;

    // counter limits and window decode constants at counter width
    localparam logic [ADDR_W-1:0]   FEAT_LAST = ADDR_W'(FEATS - 1);
    localparam logic [COLX_W-1:0]   COL_LAST  = COLX_W'(GRID_W - 1);
    localparam logic [ROWX_W-1:0]   ROW_LAST  = ROWX_W'(GRID_H - 1);
    localparam logic [COLX_W-1:0]   WIN_COL0  = COLX_W'(COL - 1);
    localparam logic [ROWX_W-1:0]   WIN_ROW0  = ROWX_W'(ROW - 1);
    localparam logic [WIN_ID_W-1:0] WIN_X_ID  = WIN_ID_W'(WIN_X);

endpackage
